//--- Makefile
VERILATOR ?= verilator
TOP ?= rv_core_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hw/rv_core.sv
`timescale 1ns/10ps

module rv_core(
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic imem_we,
	input logic [rv_pkg::imem_aw-1:0] imem_addr,
	input logic [rv_pkg::xlen-1:0] imem_wdata,
	output logic retire,
	output logic [rv_pkg::xlen-1:0] retire_pc,
	output logic [rv_pkg::xlen-1:0] retire_insn,
	output logic wb_en,
	output logic [4:0] wb_rd,
	output logic [rv_pkg::xlen-1:0] wb_data,
	output logic st_en,
	output logic [rv_pkg::xlen-1:0] st_addr,
	output logic [rv_pkg::xlen-1:0] st_data,
	output logic [3:0] st_mask,
	output logic [rv_pkg::xlen-1:0] next_pc
);

	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] insn;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [rv_pkg::xlen-1:0] imm;
	logic rd_we;
	logic [rv_pkg::xlen-1:0] src1;
	logic [rv_pkg::xlen-1:0] src2;
	logic [rv_pkg::xlen-1:0] val;
	logic taken;
	logic [rv_pkg::xlen-1:0] target;
	logic [rv_pkg::xlen-1:0] mem_addr;
	logic ex_st_en;
	logic [rv_pkg::xlen-1:0] rdata;

	rv_fetch u_fetch(
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.taken(taken),
		.target(target),
		.pc(pc),
		.insn(insn),
		.next_pc(next_pc)
	);

	rv_decode u_decode(
		.insn(insn),
		.opcode(opcode),
		.funct3(funct3),
		.funct7(funct7),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.imm(imm),
		.rd_we(rd_we)
	);

	rv_regfile u_regfile(
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.rd_we(rd_we),
		.wdata(val),
		.src1(src1),
		.src2(src2)
	);

	rv_exu u_exu(
		.opcode(opcode),
		.funct3(funct3),
		.funct7(funct7),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.pc(pc),
		.rdata(rdata),
		.val(val),
		.taken(taken),
		.target(target),
		.mem_addr(mem_addr),
		.st_en(ex_st_en),
		.st_data(st_data),
		.st_mask(st_mask)
	);

	rv_dmem u_dmem(
		.clk(clk),
		.run(run),
		.st_en(ex_st_en),
		.addr(mem_addr),
		.wdata(st_data),
		.mask(st_mask),
		.rdata(rdata)
	);

	// one instruction completes every running cycle
	assign retire = run;
	assign retire_pc = pc;
	assign retire_insn = insn;
	assign wb_en = run && rd_we;
	assign wb_rd = rd;
	assign wb_data = val;
	assign st_en = run && ex_st_en;
	assign st_addr = mem_addr;

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/10ps

module rv_decode(
	input logic [rv_pkg::xlen-1:0] insn,
	output logic [6:0] opcode,
	output logic [2:0] funct3,
	output logic [6:0] funct7,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [rv_pkg::xlen-1:0] imm,
	output logic rd_we
);

	rv_pkg::insn_t ins;
	logic writes;

	assign ins = insn;
	assign opcode = ins.r.opcode;
	assign funct3 = ins.r.funct3;
	assign funct7 = ins.r.funct7;
	assign rs1 = ins.r.rs1;
	assign rs2 = ins.r.rs2;
	assign rd = ins.r.rd;

	always_comb begin
		case (ins.r.opcode)
			rv_pkg::op_lui, rv_pkg::op_auipc:
				imm = {ins.u.imm_31_12, 12'b0};
			rv_pkg::op_jal:
				imm = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
					ins.j.imm_11, ins.j.imm_10_1, 1'b0};
			rv_pkg::op_branch:
				imm = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
					ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
			rv_pkg::op_store:
				imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
			default:
				imm = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0}; // jalr, load, op_imm
		endcase
	end

	// only the kept encodings write back, everything else is a no-op
	always_comb begin
		case (ins.r.opcode)
			rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal, rv_pkg::op_jalr:
				writes = 1'b1;
			rv_pkg::op_load:
				writes = (funct3 == rv_pkg::f3_lw) || (funct3 == rv_pkg::f3_lbu);
			rv_pkg::op_imm: begin
				case (funct3)
					rv_pkg::f3_sll:
						writes = (funct7 == 7'h00);
					rv_pkg::f3_sr:
						writes = (funct7 == 7'h00) || (funct7 == rv_pkg::f7_alt);
					rv_pkg::f3_add, rv_pkg::f3_sltiu, rv_pkg::f3_xor, rv_pkg::f3_and:
						writes = 1'b1;
					default:
						writes = 1'b0;
				endcase
			end
			rv_pkg::op_reg: begin
				case (funct3)
					rv_pkg::f3_add:
						writes = (funct7 == 7'h00) || (funct7 == rv_pkg::f7_alt);
					rv_pkg::f3_sll, rv_pkg::f3_sltu, rv_pkg::f3_xor, rv_pkg::f3_or,
					rv_pkg::f3_and:
						writes = (funct7 == 7'h00);
					default:
						writes = 1'b0; // srl, sra, slt not kept
				endcase
			end
			default:
				writes = 1'b0;
		endcase
	end

	assign rd_we = writes && (rd != 5'd0);

endmodule

//--- hw/rv_dmem.sv
`timescale 1ns/10ps

module rv_dmem(
	input logic clk,
	input logic run,
	input logic st_en,
	input logic [rv_pkg::xlen-1:0] addr,
	input logic [rv_pkg::xlen-1:0] wdata,
	input logic [3:0] mask,
	output logic [rv_pkg::xlen-1:0] rdata
);

	logic [rv_pkg::xlen-1:0] mem [rv_pkg::dmem_depth];
	logic [rv_pkg::dmem_aw-1:0] widx;

	assign widx = addr[rv_pkg::dmem_aw+1:2]; // low two bits ignored
	assign rdata = mem[widx];

	always_ff @(posedge clk) begin
		if (run && st_en) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (mask[lane]) begin
					mem[widx][lane*8 +: 8] <= wdata[lane*8 +: 8];
				end
			end
		end
	end

endmodule

//--- hw/rv_exu.sv
`timescale 1ns/10ps

module rv_exu(
	input logic [6:0] opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	input logic [rv_pkg::xlen-1:0] src1,
	input logic [rv_pkg::xlen-1:0] src2,
	input logic [rv_pkg::xlen-1:0] imm,
	input logic [rv_pkg::xlen-1:0] pc,
	input logic [rv_pkg::xlen-1:0] rdata,
	output logic [rv_pkg::xlen-1:0] val,
	output logic taken,
	output logic [rv_pkg::xlen-1:0] target,
	output logic [rv_pkg::xlen-1:0] mem_addr,
	output logic st_en,
	output logic [rv_pkg::xlen-1:0] st_data,
	output logic [3:0] st_mask
);

	logic [rv_pkg::xlen-1:0] link;
	logic [rv_pkg::xlen-1:0] pc_rel;
	logic [4:0] shamt_i;
	logic [4:0] shamt_r;
	logic eq;

	assign link = pc + 32'd4;
	assign pc_rel = pc + imm; // auipc, jal, branches
	assign mem_addr = src1 + imm;
	assign st_data = src2;
	assign shamt_i = imm[4:0];
	assign shamt_r = src2[4:0];
	assign eq = (src1 == src2);

	always_comb begin
		val = '0;
		taken = 1'b0;
		target = pc_rel;
		st_en = 1'b0;
		st_mask = 4'h0;
		case (opcode)
			rv_pkg::op_lui:
				val = imm;
			rv_pkg::op_auipc:
				val = pc_rel;
			rv_pkg::op_jal: begin
				val = link;
				taken = 1'b1;
			end
			rv_pkg::op_jalr: begin
				val = link;
				taken = 1'b1;
				target = mem_addr & ~32'd1; // shares the address adder
			end
			rv_pkg::op_branch: begin
				case (funct3)
					rv_pkg::f3_beq:
						taken = eq;
					rv_pkg::f3_bne:
						taken = !eq;
					rv_pkg::f3_bge:
						taken = $signed(src1) >= $signed(src2);
					rv_pkg::f3_bgeu:
						taken = src1 >= src2;
					default:
						taken = 1'b0;
				endcase
			end
			rv_pkg::op_load: begin
				if (funct3 == rv_pkg::f3_lw) begin
					val = rdata;
				end else if (funct3 == rv_pkg::f3_lbu) begin
					val = {24'b0, rdata[7:0]};
				end
			end
			rv_pkg::op_store: begin
				case (funct3)
					rv_pkg::f3_sb:
						st_mask = 4'h1;
					rv_pkg::f3_sh:
						st_mask = 4'h3;
					rv_pkg::f3_sw:
						st_mask = 4'hf;
					default:
						st_mask = 4'h0;
				endcase
				st_en = |st_mask;
			end
			rv_pkg::op_imm: begin
				case (funct3)
					rv_pkg::f3_add:
						val = src1 + imm;
					rv_pkg::f3_sltiu:
						val = {31'b0, (src1 < imm)};
					rv_pkg::f3_xor:
						val = src1 ^ imm;
					rv_pkg::f3_and:
						val = src1 & imm;
					rv_pkg::f3_sll: begin
						if (funct7 == 7'h00) begin
							val = src1 << shamt_i;
						end
					end
					rv_pkg::f3_sr: begin
						if (funct7 == 7'h00) begin
							val = src1 >> shamt_i;
						end else if (funct7 == rv_pkg::f7_alt) begin
							val = $signed(src1) >>> shamt_i;
						end
					end
					default:
						val = '0;
				endcase
			end
			rv_pkg::op_reg: begin
				case ({funct7, funct3})
					{7'h00, rv_pkg::f3_add}:
						val = src1 + src2;
					{rv_pkg::f7_alt, rv_pkg::f3_add}:
						val = src1 - src2;
					{7'h00, rv_pkg::f3_sll}:
						val = src1 << shamt_r;
					{7'h00, rv_pkg::f3_sltu}:
						val = {31'b0, (src1 < src2)};
					{7'h00, rv_pkg::f3_xor}:
						val = src1 ^ src2;
					{7'h00, rv_pkg::f3_or}:
						val = src1 | src2;
					{7'h00, rv_pkg::f3_and}:
						val = src1 & src2;
					default:
						val = '0;
				endcase
			end
			default:
				val = '0; // unknown, no-op
		endcase
	end

endmodule

//--- hw/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch(
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic imem_we,
	input logic [rv_pkg::imem_aw-1:0] imem_addr,
	input logic [rv_pkg::xlen-1:0] imem_wdata,
	input logic taken,
	input logic [rv_pkg::xlen-1:0] target,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] insn,
	output logic [rv_pkg::xlen-1:0] next_pc
);

	logic [rv_pkg::xlen-1:0] imem [rv_pkg::imem_depth];
	logic [rv_pkg::imem_aw-1:0] widx;

	assign widx = pc[rv_pkg::imem_aw+1:2]; // word index
	assign insn = imem[widx];
	assign next_pc = taken ? target : pc + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (run) begin
			pc <= next_pc;
		end
	end

	// program load port, host side
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;
	localparam int imem_aw = $clog2(imem_depth);
	localparam int dmem_aw = $clog2(dmem_depth);

	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bgeu = 3'b111;
	localparam logic [2:0] f3_lw = 3'b010;
	localparam logic [2:0] f3_lbu = 3'b100;
	localparam logic [2:0] f3_sb = 3'b000;
	localparam logic [2:0] f3_sh = 3'b001;
	localparam logic [2:0] f3_sw = 3'b010;
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_sr = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_sltiu = 3'b011;

	localparam logic [6:0] f7_alt = 7'b0100000; // sub, srai

	// one instruction word, six ways of reading it
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} u;
		struct packed {
			logic imm_20;
			logic [9:0] imm_10_1;
			logic imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} insn_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile(
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic rd_we,
	input logic [rv_pkg::xlen-1:0] wdata,
	output logic [rv_pkg::xlen-1:0] src1,
	output logic [rv_pkg::xlen-1:0] src2
);

	logic [rv_pkg::xlen-1:0] regs [32];

	// x0 reads as zero whatever the array holds
	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (rst_n && run && rd_we) begin // held off during reset
			regs[rd] <= wdata;
		end
	end

endmodule

//--- project.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_exu.sv
hw/rv_regfile.sv
hw/rv_dmem.sv
hw/rv_core.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

//--- tb/rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker(
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic retire,
	input logic [31:0] retire_pc,
	input logic [31:0] retire_insn,
	input logic wb_en,
	input logic [4:0] wb_rd,
	input logic [31:0] wb_data,
	input logic st_en,
	input logic [31:0] st_addr,
	input logic [31:0] st_data,
	input logic [3:0] st_mask,
	input logic [31:0] next_pc
);

	rv_pkg::insn_t ins;
	logic [31:0] sreg [32];
	logic [31:0] smem [rv_pkg::dmem_depth];
	logic [6:0] op;
	logic [2:0] f3;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] opnd;
	logic [4:0] shamt;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] ld_addr;
	logic [31:0] mword;
	logic [31:0] ld_exp;
	logic [31:0] alu_exp;
	logic [3:0] mask_exp;
	logic cond;
	logic ctl;
	logic [31:0] pc_exp;
	int fail_cnt = 0;

	assign ins = retire_insn;
	assign op = ins.r.opcode;
	assign f3 = ins.r.funct3;
	assign a = (ins.r.rs1 == 5'd0) ? 32'd0 : sreg[ins.r.rs1]; // x0 reads zero
	assign b = (ins.r.rs2 == 5'd0) ? 32'd0 : sreg[ins.r.rs2];
	assign imm_i = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
	assign imm_s = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
	assign imm_b = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
	assign imm_u = {ins.u.imm_31_12, 12'd0};
	assign imm_j = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11, ins.j.imm_10_1, 1'b0};
	assign opnd = (op == rv_pkg::op_reg) ? b : imm_i;
	assign shamt = opnd[4:0];
	assign ld_addr = a + imm_i;
	assign mword = smem[ld_addr[rv_pkg::dmem_aw+1:2]];
	assign ld_exp = (f3 == rv_pkg::f3_lw) ? mword : {24'd0, mword[7:0]};
	assign mask_exp = (f3 == rv_pkg::f3_sb) ? 4'h1 : (f3 == rv_pkg::f3_sh) ? 4'h3 : 4'hf;
	assign ctl = (op == rv_pkg::op_branch) || (op == rv_pkg::op_jal) ||
		(op == rv_pkg::op_jalr); // branches and jumps

	always_comb begin
		case (f3)
			rv_pkg::f3_add:
				alu_exp = (op == rv_pkg::op_reg && ins.r.funct7 == rv_pkg::f7_alt) ?
					a - opnd : a + opnd;
			rv_pkg::f3_sll: alu_exp = a << shamt;
			rv_pkg::f3_sltu: alu_exp = {31'd0, a < opnd};
			rv_pkg::f3_xor: alu_exp = a ^ opnd;
			rv_pkg::f3_sr: begin
				if (ins.r.funct7 == rv_pkg::f7_alt) begin
					alu_exp = $signed(a) >>> shamt;
				end else begin
					alu_exp = a >> shamt;
				end
			end
			rv_pkg::f3_or: alu_exp = a | opnd;
			default: alu_exp = a & opnd;
		endcase
	end

	always_comb begin
		case (f3)
			rv_pkg::f3_beq: cond = (a == b);
			rv_pkg::f3_bne: cond = (a != b);
			rv_pkg::f3_bge: cond = ($signed(a) >= $signed(b));
			default: cond = (a >= b); // bgeu
		endcase
	end

	always_ff @(posedge clk) begin
		if (wb_en) begin
			sreg[wb_rd] <= wb_data;
		end
		if (st_en) begin
			for (int i = 0; i < 4; i++) begin
				if (st_mask[i]) begin
					smem[st_addr[rv_pkg::dmem_aw+1:2]][i*8 +: 8] <= st_data[i*8 +: 8];
				end
			end
		end
	end

	// pc the next retiring instruction must carry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_exp <= '0;
		end else if (retire) begin
			pc_exp <= ctl ? next_pc : pc_exp + 32'd4;
		end
	end

	a_alu: assert property (@(posedge clk) disable iff (!rst_n)
		retire && (op == rv_pkg::op_imm || op == rv_pkg::op_reg)
		|-> wb_en == (ins.r.rd != 5'd0) && wb_data == alu_exp)
		else begin
			fail_cnt++;
			$error("Fail alu wb_data 0x%h, expected 0x%h",
				$sampled(wb_data), $sampled(alu_exp));
		end

	a_load: assert property (@(posedge clk) disable iff (!rst_n)
		retire && op == rv_pkg::op_load |-> wb_data == ld_exp)
		else begin
			fail_cnt++;
			$error("Fail load wb_data 0x%h, expected 0x%h",
				$sampled(wb_data), $sampled(ld_exp));
		end

	a_store: assert property (@(posedge clk) disable iff (!rst_n)
		retire && op == rv_pkg::op_store
		|-> st_en && st_addr == a + imm_s && st_data == b && st_mask == mask_exp)
		else begin
			fail_cnt++;
			$error("Fail store st_addr 0x%h st_mask 0x%h", $sampled(st_addr), $sampled(st_mask));
		end

	a_branch: assert property (@(posedge clk) disable iff (!rst_n)
		retire && op == rv_pkg::op_branch
		|-> next_pc == (cond ? retire_pc + imm_b : retire_pc + 32'd4))
		else begin
			fail_cnt++;
			$error("Fail branch next_pc 0x%h at pc 0x%h", $sampled(next_pc), $sampled(retire_pc));
		end

	a_jump: assert property (@(posedge clk) disable iff (!rst_n)
		retire && (op == rv_pkg::op_jal || op == rv_pkg::op_jalr)
		|-> wb_data == retire_pc + 32'd4 && next_pc ==
		((op == rv_pkg::op_jal) ? retire_pc + imm_j : (a + imm_i) & ~32'd1))
		else begin
			fail_cnt++;
			$error("Fail jump next_pc 0x%h wb_data 0x%h", $sampled(next_pc), $sampled(wb_data));
		end

	a_upper: assert property (@(posedge clk) disable iff (!rst_n)
		retire && (op == rv_pkg::op_lui || op == rv_pkg::op_auipc)
		|-> wb_data == ((op == rv_pkg::op_lui) ? imm_u : retire_pc + imm_u))
		else begin
			fail_cnt++;
			$error("Fail upper imm wb_data 0x%h", $sampled(wb_data));
		end

	a_pc: assert property (@(posedge clk) disable iff (!rst_n)
		retire |-> retire_pc == pc_exp)
		else begin
			fail_cnt++;
			$error("Fail retire_pc 0x%h, expected 0x%h", $sampled(retire_pc), $sampled(pc_exp));
		end

	a_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!run |-> !retire && !wb_en && !st_en)
		else begin
			fail_cnt++;
			$error("core active while run is low");
		end

	a_x0: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> wb_rd != 5'd0)
		else begin
			fail_cnt++;
			$error("write to x0 raised wb_en");
		end

endmodule

bind rv_core rv_core_checker chk(.*);

//--- tb/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

	logic clk = 1'b0;
	logic rst_n;
	logic run;
	logic imem_we;
	logic [7:0] imem_addr;
	logic [31:0] imem_wdata;
	logic retire;
	logic [31:0] retire_pc;
	logic [31:0] retire_insn;
	logic wb_en;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;
	logic st_en;
	logic [31:0] st_addr;
	logic [31:0] st_data;
	logic [3:0] st_mask;
	logic [31:0] next_pc;
	logic [31:0] prog [$];
	int n_pass = 0;
	int n_fail = 0;

	rv_core dut(.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
	endfunction

	function automatic logic [31:0] i_type(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
		logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::op_store};
	endfunction

	function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
	endfunction

	function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
	endfunction

	// lui/addi pair with the upper part rounded for the signed low half
	task automatic set_reg_const(logic [4:0] rd, logic [31:0] v);
		prog.push_back(u_type(rv_pkg::op_lui, rd, v[31:12] + {19'd0, v[11]}));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_add, rd, rd, v[11:0]));
	endtask

	// branch over one filler instruction
	task automatic branch_over_filler(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
		prog.push_back(b_type(f3, rs1, rs2, 13'd8));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_add, 5'd9, 5'd9, 12'd1));
	endtask

	task automatic reset_core();
		@(posedge clk);
		run <= 1'b0;
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic load_program();
		prog.push_back(j_type(5'd0, 21'd0)); // park on a self loop
		for (int k = 0; k < prog.size(); k++) begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= k[7:0];
			imem_wdata <= prog[k];
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	task automatic run_program(string name);
		int n;
		int seen;
		int cycles;
		int errs;
		n = prog.size();
		seen = 0;
		cycles = 0;
		errs = dut.chk.fail_cnt;
		reset_core();
		load_program();
		run <= 1'b1;
		while (seen < n && cycles < 20 * n) begin
			@(posedge clk);
			if (retire) begin
				seen++;
			end
			run <= ($urandom % 4) != 0; // random stalls
			cycles++;
		end
		run <= 1'b0;
		@(posedge clk);
		prog.delete();
		if (seen < n) begin
			$display("%s: timeout, only %0d of %0d instructions retired", name, seen, n);
			n_fail++;
		end else if (dut.chk.fail_cnt != errs) begin
			$display("Fail %s: fail_cnt = 0x%0h, expected 0x%0h",
				name, dut.chk.fail_cnt, errs);
			n_fail++;
		end else begin
			$display("%s: pass", name);
			n_pass++;
		end
	endtask

	initial begin
		logic [31:0] rnd;
		void'($urandom(32'h9ec6_e47a));
		rst_n = 1'b0;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;

		rnd = $urandom;
		set_reg_const(5'd1, $urandom);
		set_reg_const(5'd2, $urandom);
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_add, 5'd3, 5'd1, rnd[11:0]));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_sltiu, 5'd4, 5'd1, rnd[23:12]));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_xor, 5'd5, 5'd2, rnd[11:0]));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_and, 5'd6, 5'd2, rnd[23:12]));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_sll, 5'd7, 5'd1,
			{7'h00, rnd[28:24]}));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_sr, 5'd8, 5'd1, {7'h00, rnd[4:0]}));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_sr, 5'd9, 5'd2,
			{rv_pkg::f7_alt, rnd[9:5]}));
		prog.push_back(r_type(7'h00, rv_pkg::f3_add, 5'd10, 5'd1, 5'd2));
		prog.push_back(r_type(rv_pkg::f7_alt, rv_pkg::f3_add, 5'd11, 5'd1, 5'd2));
		prog.push_back(r_type(7'h00, rv_pkg::f3_sll, 5'd12, 5'd1, 5'd2));
		prog.push_back(r_type(7'h00, rv_pkg::f3_sltu, 5'd13, 5'd1, 5'd2));
		prog.push_back(r_type(7'h00, rv_pkg::f3_xor, 5'd14, 5'd1, 5'd2));
		prog.push_back(r_type(7'h00, rv_pkg::f3_or, 5'd15, 5'd1, 5'd2));
		prog.push_back(r_type(7'h00, rv_pkg::f3_and, 5'd16, 5'd1, 5'd2));
		prog.push_back(r_type(7'h00, rv_pkg::f3_add, 5'd17, 5'd0, 5'd2)); // x0 as source
		prog.push_back(r_type(7'h00, rv_pkg::f3_add, 5'd0, 5'd1, 5'd2)); // x0 as target
		run_program("alu");

		rnd = $urandom;
		set_reg_const(5'd1, 32'h100 + {24'd0, rnd[7:4], 4'd0}); // word aligned base
		set_reg_const(5'd2, $urandom);
		set_reg_const(5'd3, $urandom);
		prog.push_back(s_type(rv_pkg::f3_sw, 5'd2, 5'd1, 12'd0));
		prog.push_back(i_type(rv_pkg::op_load, rv_pkg::f3_lw, 5'd4, 5'd1, 12'd0));
		prog.push_back(s_type(rv_pkg::f3_sb, 5'd3, 5'd1, 12'd4));
		prog.push_back(i_type(rv_pkg::op_load, rv_pkg::f3_lbu, 5'd5, 5'd1, 12'd4));
		prog.push_back(s_type(rv_pkg::f3_sh, 5'd3, 5'd1, 12'd8));
		prog.push_back(i_type(rv_pkg::op_load, rv_pkg::f3_lbu, 5'd6, 5'd1, 12'd8));
		prog.push_back(s_type(rv_pkg::f3_sw, 5'd3, 5'd1, 12'd0));
		prog.push_back(i_type(rv_pkg::op_load, rv_pkg::f3_lbu, 5'd7, 5'd1, 12'd0));
		prog.push_back(i_type(rv_pkg::op_load, rv_pkg::f3_lw, 5'd8, 5'd1, 12'd0));
		run_program("load_store");

		set_reg_const(5'd1, $urandom);
		set_reg_const(5'd2, $urandom);
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_add, 5'd3, 5'd1, 12'd0));
		branch_over_filler(rv_pkg::f3_beq, 5'd1, 5'd3);
		branch_over_filler(rv_pkg::f3_beq, 5'd1, 5'd2);
		branch_over_filler(rv_pkg::f3_bne, 5'd1, 5'd2);
		branch_over_filler(rv_pkg::f3_bne, 5'd1, 5'd3);
		branch_over_filler(rv_pkg::f3_bge, 5'd1, 5'd2);
		branch_over_filler(rv_pkg::f3_bge, 5'd2, 5'd1);
		branch_over_filler(rv_pkg::f3_bgeu, 5'd1, 5'd2);
		branch_over_filler(rv_pkg::f3_bgeu, 5'd2, 5'd1);
		run_program("branch");

		rnd = $urandom;
		set_reg_const(5'd2, $urandom);
		prog.push_back(u_type(rv_pkg::op_lui, 5'd5, rnd[19:0]));
		prog.push_back(u_type(rv_pkg::op_auipc, 5'd6, rnd[31:12]));
		prog.push_back(j_type(5'd7, 21'd8));
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_add, 5'd9, 5'd9, 12'd1));
		prog.push_back(u_type(rv_pkg::op_auipc, 5'd1, 20'd0));
		prog.push_back(i_type(rv_pkg::op_jalr, 3'b000, 5'd8, 5'd1, 12'd13)); // odd offset
		prog.push_back(i_type(rv_pkg::op_imm, rv_pkg::f3_add, 5'd9, 5'd9, 12'd1));
		prog.push_back(r_type(7'h00, rv_pkg::f3_add, 5'd10, 5'd2, 5'd8));
		run_program("jump_upper");

		$display("tests: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0 && dut.chk.fail_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
